// ==== verilog/lc3b_types.sv ====
`default_nettype none

package lc3b_types;

    // data and byte address word
    typedef logic [15:0] lc3b_word;

    // register file index
    typedef logic [2:0] lc3b_reg;

    // condition codes, n in bit 2, z in bit 1, p in bit 0
    typedef logic [2:0] lc3b_nzp;

    // ir[15:12], only the supported subset is named
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_alu_op;

    // pipeline controller
    typedef enum logic [1:0] {
        ctrl_run,
        ctrl_mem_wait,
        ctrl_redirect
    } ctrl_state;

endpackage : lc3b_types

`default_nettype wire

// ==== verilog/pipeline_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipeline_control (
    input  logic clk,
    input  logic rst_n,
    input  logic mem_busy,
    input  logic branch_taken,
    input  logic fetch_valid,
    input  logic fetch_pending,
    output logic hold_all,
    output logic bubble_id,
    output logic flush,
    output logic discard_fetch
);

    import lc3b_types::*;

    ctrl_state state;
    ctrl_state state_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ctrl_run;
        end else begin
            state <= state_next;
        end
    end

    // stale wrong-path ack is dropped while redirecting
    assign discard_fetch = (state == ctrl_redirect);

    always_comb begin
        state_next = state;
        hold_all   = 1'b0;
        bubble_id  = 1'b0;
        flush      = 1'b0;
        case (state)
            ctrl_run: begin
                if (mem_busy) begin
                    hold_all   = 1'b1;
                    state_next = ctrl_mem_wait;
                end else if (branch_taken) begin
                    flush = 1'b1;
                    // old request still on the bus, its ack must not enter IF/ID
                    if (fetch_pending) begin
                        state_next = ctrl_redirect;
                    end
                end else begin
                    bubble_id = !fetch_valid;
                end
            end
            ctrl_mem_wait: begin
                if (mem_busy) begin
                    hold_all = 1'b1;
                end else begin
                    bubble_id  = !fetch_valid;
                    state_next = ctrl_run;
                end
            end
            ctrl_redirect: begin
                bubble_id = 1'b1;
                if (!fetch_pending) begin
                    state_next = ctrl_run;
                end
            end
            default: begin
                state_next = ctrl_run;
            end
        endcase
    end

    // a frozen pipeline can never be redirected at the same time
    assert property (@(posedge clk) disable iff (!rst_n) !(hold_all && flush));

endmodule : pipeline_control

`default_nettype wire

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_unit #(
    parameter lc3b_types::lc3b_word RESET_PC = 16'h0000
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 hold_all,
    input  logic                 flush,
    input  logic                 discard_fetch,
    input  lc3b_types::lc3b_word branch_target,
    output logic                 imem_cyc,
    output logic                 imem_stb,
    output lc3b_types::lc3b_word imem_adr,
    input  lc3b_types::lc3b_word imem_dat_r,
    input  logic                 imem_ack,
    output logic                 fetch_valid,
    output logic                 fetch_pending,
    output lc3b_types::lc3b_word fetch_ir,
    output lc3b_types::lc3b_word fetch_pc
);

    import lc3b_types::*;

    logic     pending;
    lc3b_word pc;
    lc3b_word next_adr;
    logic     live_ack;
    logic     issue;
    logic     buf_valid;
    lc3b_word buf_ir;
    lc3b_word buf_pc;

    assign live_ack = pending && imem_ack && !discard_fetch;
    // new request once the bus slot frees up, never while frozen
    assign issue    = !hold_all && (!pending || imem_ack);
    assign next_adr = flush ? branch_target : pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending   <= 1'b0;
            pc        <= RESET_PC;
            imem_adr  <= RESET_PC;
            buf_valid <= 1'b0;
        end else begin
            if (issue) begin
                pending  <= 1'b1;
                imem_adr <= next_adr;
                pc       <= next_adr + 16'd2;
            end else begin
                if (imem_ack) begin
                    pending <= 1'b0;
                end
                // target waits in pc until the outstanding request completes
                if (flush) begin
                    pc <= branch_target;
                end
            end
            if (flush || !hold_all) begin
                buf_valid <= 1'b0;
            end else if (live_ack) begin
                buf_valid <= 1'b1;
            end
        end
    end

    // instruction acked while the pipeline is frozen
    always_ff @(posedge clk) begin
        if (hold_all && live_ack) begin
            buf_ir <= imem_dat_r;
            buf_pc <= imem_adr + 16'd2;
        end
    end

    assign imem_cyc      = pending;
    assign imem_stb      = pending;
    assign fetch_pending = pending && !imem_ack;
    assign fetch_valid   = buf_valid || live_ack;
    assign fetch_ir      = buf_valid ? buf_ir : imem_dat_r;
    assign fetch_pc      = buf_valid ? buf_pc : imem_adr + 16'd2;

    assert property (@(posedge clk) disable iff (!rst_n)
        (imem_stb && !imem_ack) |=> $stable(imem_adr));

endmodule : fetch_unit

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   hold_all,
    input  logic                   bubble_id,
    input  logic                   flush,
    input  logic                   fetch_valid,
    input  lc3b_types::lc3b_word   fetch_ir,
    input  lc3b_types::lc3b_word   fetch_pc,
    input  logic                   wb_load,
    input  lc3b_types::lc3b_reg    wb_dest,
    input  lc3b_types::lc3b_word   wb_data,
    output logic                   ex_valid,
    output lc3b_types::lc3b_opcode ex_opcode,
    output lc3b_types::lc3b_alu_op ex_alu_op,
    output lc3b_types::lc3b_reg    ex_dest,
    output lc3b_types::lc3b_word   ex_sr1_val,
    output lc3b_types::lc3b_word   ex_sr2_val,
    output lc3b_types::lc3b_word   ex_imm,
    output lc3b_types::lc3b_word   ex_pc,
    output logic                   ex_use_imm,
    output lc3b_types::lc3b_nzp    ex_nzp_mask
);

    import lc3b_types::*;

    logic       ifid_valid;
    lc3b_word   ifid_ir;
    lc3b_word   ifid_pc;
    lc3b_opcode opcode;
    logic       supported;
    lc3b_alu_op alu_op;
    lc3b_reg    dest;
    lc3b_reg    sr1;
    lc3b_reg    sr2;
    lc3b_word   imm;
    logic       use_imm;
    lc3b_nzp    nzp_mask;
    lc3b_word   sr1_val;
    lc3b_word   sr2_val;
    lc3b_word   regs [8];

    // IF/ID barrier
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ifid_valid <= 1'b0;
        end else if (flush) begin
            ifid_valid <= 1'b0;
        end else if (!hold_all) begin
            ifid_valid <= fetch_valid && !bubble_id;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_all && fetch_valid) begin
            ifid_ir <= fetch_ir;
            ifid_pc <= fetch_pc;
        end
    end

    assign opcode = lc3b_opcode'(ifid_ir[15:12]);

    always_comb begin
        supported = 1'b1;
        alu_op    = alu_add;
        dest      = ifid_ir[11:9];
        sr1       = ifid_ir[8:6];
        sr2       = ifid_ir[2:0];
        imm       = {{11{ifid_ir[4]}}, ifid_ir[4:0]};
        use_imm   = ifid_ir[5];
        nzp_mask  = 3'b000;
        case (opcode)
            op_add: alu_op = alu_add;
            op_and: alu_op = alu_and;
            op_not: alu_op = alu_not;
            op_ldr, op_str: begin
                imm     = {{9{ifid_ir[5]}}, ifid_ir[5:0], 1'b0};
                use_imm = 1'b1;
                // store data register sits in the dest field
                sr2     = ifid_ir[11:9];
            end
            op_br: begin
                alu_op   = alu_pass;
                imm      = {{6{ifid_ir[8]}}, ifid_ir[8:0], 1'b0};
                use_imm  = 1'b1;
                nzp_mask = ifid_ir[11:9];
            end
            default: supported = 1'b0;
        endcase
    end

    // register file, same-cycle writes pass through to the read ports
    always_ff @(posedge clk) begin
        if (wb_load) begin
            regs[wb_dest] <= wb_data;
        end
    end

    assign sr1_val = (wb_load && wb_dest == sr1) ? wb_data : regs[sr1];
    assign sr2_val = (wb_load && wb_dest == sr2) ? wb_data : regs[sr2];

    // ID/EX barrier
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;
        end else if (!hold_all) begin
            ex_valid <= ifid_valid && supported;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_all) begin
            ex_opcode   <= opcode;
            ex_alu_op   <= alu_op;
            ex_dest     <= dest;
            ex_sr1_val  <= sr1_val;
            ex_sr2_val  <= sr2_val;
            ex_imm      <= imm;
            ex_use_imm  <= use_imm;
            ex_nzp_mask <= nzp_mask;
            ex_pc       <= ifid_pc;
        end
    end

endmodule : decode_stage

`default_nettype wire

// ==== verilog/execute_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   hold_all,
    input  logic                   ex_valid,
    input  lc3b_types::lc3b_opcode ex_opcode,
    input  lc3b_types::lc3b_alu_op ex_alu_op,
    input  lc3b_types::lc3b_reg    ex_dest,
    input  lc3b_types::lc3b_word   ex_sr1_val,
    input  lc3b_types::lc3b_word   ex_sr2_val,
    input  lc3b_types::lc3b_word   ex_imm,
    input  lc3b_types::lc3b_word   ex_pc,
    input  logic                   ex_use_imm,
    input  lc3b_types::lc3b_nzp    ex_nzp_mask,
    output logic                   dmem_cyc,
    output logic                   dmem_stb,
    output logic                   dmem_we,
    output lc3b_types::lc3b_word   dmem_adr,
    output lc3b_types::lc3b_word   dmem_dat_w,
    input  lc3b_types::lc3b_word   dmem_dat_r,
    input  logic                   dmem_ack,
    output logic                   mem_busy,
    output logic                   branch_taken,
    output lc3b_types::lc3b_word   branch_target,
    output logic                   wb_load,
    output lc3b_types::lc3b_reg    wb_dest,
    output lc3b_types::lc3b_word   wb_data
);

    import lc3b_types::*;

    logic     is_load;
    logic     is_store;
    logic     is_mem;
    logic     writes_alu;
    lc3b_word operand_b;
    lc3b_word alu_out;
    lc3b_nzp  cc;

    function automatic lc3b_nzp nzp_of(lc3b_word value);
        nzp_of = {value[15], value == 16'h0000, !value[15] && (value != 16'h0000)};
    endfunction

    assign is_load    = ex_valid && (ex_opcode == op_ldr);
    assign is_store   = ex_valid && (ex_opcode == op_str);
    assign is_mem     = is_load || is_store;
    assign writes_alu = ex_valid && (ex_opcode == op_add || ex_opcode == op_and ||
                                     ex_opcode == op_not);

    assign operand_b = ex_use_imm ? ex_imm : ex_sr2_val;

    // also forms base plus offset for LDR and STR
    always_comb begin
        alu_out = operand_b;
        case (ex_alu_op)
            alu_add:  alu_out = ex_sr1_val + operand_b;
            alu_and:  alu_out = ex_sr1_val & operand_b;
            alu_not:  alu_out = ~ex_sr1_val;
            alu_pass: alu_out = operand_b;
        endcase
    end

    // data master, held stable by the frozen ID/EX barrier until ack
    assign dmem_cyc   = is_mem;
    assign dmem_stb   = is_mem;
    assign dmem_we    = is_store;
    assign dmem_adr   = alu_out;
    assign dmem_dat_w = ex_sr2_val;
    assign mem_busy   = is_mem && !dmem_ack;

    // writeback, loads complete in the ack cycle
    assign wb_load = writes_alu || (is_load && dmem_ack);
    assign wb_dest = ex_dest;
    assign wb_data = is_load ? dmem_dat_r : alu_out;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cc <= 3'b010;
        end else if (wb_load) begin
            cc <= nzp_of(wb_data);
        end
    end

    // mask of zero never matches
    assign branch_taken  = ex_valid && (ex_opcode == op_br) && ((ex_nzp_mask & cc) != 3'b000);
    assign branch_target = ex_pc + ex_imm;

    assert property (@(posedge clk) disable iff (!rst_n)
        (dmem_stb && !dmem_ack) |=> $stable(dmem_adr));

    // a waiting access relies on the controller to freeze every stage
    assert property (@(posedge clk) disable iff (!rst_n) mem_busy |-> hold_all);

endmodule : execute_stage

`default_nettype wire

// ==== verilog/cpu.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu #(
    parameter lc3b_types::lc3b_word RESET_PC = 16'h0000
) (
    input  logic                 clk,
    input  logic                 rst_n,

    // instruction port
    output logic                 imem_cyc,
    output logic                 imem_stb,
    output lc3b_types::lc3b_word imem_adr,
    input  lc3b_types::lc3b_word imem_dat_r,
    input  logic                 imem_ack,

    // data port
    output logic                 dmem_cyc,
    output logic                 dmem_stb,
    output logic                 dmem_we,
    output lc3b_types::lc3b_word dmem_adr,
    output lc3b_types::lc3b_word dmem_dat_w,
    input  lc3b_types::lc3b_word dmem_dat_r,
    input  logic                 dmem_ack,

    // every register write
    output logic                 debug_reg_load,
    output lc3b_types::lc3b_reg  debug_reg_dest,
    output lc3b_types::lc3b_word debug_reg_data
);

    import lc3b_types::*;

    logic       hold_all;
    logic       bubble_id;
    logic       flush;
    logic       discard_fetch;
    logic       mem_busy;
    logic       branch_taken;
    lc3b_word   branch_target;
    logic       fetch_valid;
    logic       fetch_pending;
    lc3b_word   fetch_ir;
    lc3b_word   fetch_pc;
    logic       ex_valid;
    lc3b_opcode ex_opcode;
    lc3b_alu_op ex_alu_op;
    lc3b_reg    ex_dest;
    lc3b_word   ex_sr1_val;
    lc3b_word   ex_sr2_val;
    lc3b_word   ex_imm;
    lc3b_word   ex_pc;
    logic       ex_use_imm;
    lc3b_nzp    ex_nzp_mask;
    logic       wb_load;
    lc3b_reg    wb_dest;
    lc3b_word   wb_data;

    pipeline_control pipeline_control_inst (
        .clk,
        .rst_n,
        .mem_busy,
        .branch_taken,
        .fetch_valid,
        .fetch_pending,
        .hold_all,
        .bubble_id,
        .flush,
        .discard_fetch
    );

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) fetch_unit_inst (
        .clk,
        .rst_n,
        .hold_all,
        .flush,
        .discard_fetch,
        .branch_target,
        .imem_cyc,
        .imem_stb,
        .imem_adr,
        .imem_dat_r,
        .imem_ack,
        .fetch_valid,
        .fetch_pending,
        .fetch_ir,
        .fetch_pc
    );

    decode_stage decode_stage_inst (
        .clk,
        .rst_n,
        .hold_all,
        .bubble_id,
        .flush,
        .fetch_valid,
        .fetch_ir,
        .fetch_pc,
        .wb_load,
        .wb_dest,
        .wb_data,
        .ex_valid,
        .ex_opcode,
        .ex_alu_op,
        .ex_dest,
        .ex_sr1_val,
        .ex_sr2_val,
        .ex_imm,
        .ex_pc,
        .ex_use_imm,
        .ex_nzp_mask
    );

    execute_stage execute_stage_inst (
        .clk,
        .rst_n,
        .hold_all,
        .ex_valid,
        .ex_opcode,
        .ex_alu_op,
        .ex_dest,
        .ex_sr1_val,
        .ex_sr2_val,
        .ex_imm,
        .ex_pc,
        .ex_use_imm,
        .ex_nzp_mask,
        .dmem_cyc,
        .dmem_stb,
        .dmem_we,
        .dmem_adr,
        .dmem_dat_w,
        .dmem_dat_r,
        .dmem_ack,
        .mem_busy,
        .branch_taken,
        .branch_target,
        .wb_load,
        .wb_dest,
        .wb_data
    );

    assign debug_reg_load = wb_load;
    assign debug_reg_dest = wb_dest;
    assign debug_reg_data = wb_data;

endmodule : cpu

`default_nettype wire

// ==== tb/wb_memory_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_memory_model #(
    parameter int AW = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  lc3b_types::lc3b_word adr,
    input  lc3b_types::lc3b_word dat_w,
    output lc3b_types::lc3b_word dat_r,
    output logic                 ack
);

    import lc3b_types::*;

    // word array, indexed by the byte address without bit 0
    lc3b_word    mem [2**AW];
    logic        ack_q = 1'b0;
    lc3b_word    dat_q = 16'h0000;
    logic        busy  = 1'b0;
    int unsigned wait_left;
    int unsigned delay;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q     <= 1'b0;
            busy      <= 1'b0;
            wait_left <= 0;
        end else begin
            ack_q <= 1'b0;
            // no new transfer starts in the ack cycle itself
            if (cyc && stb && !ack_q) begin
                if (!busy) begin
                    delay = $urandom % 4;
                    if (delay == 0) begin
                        ack_q <= 1'b1;
                        dat_q <= mem[adr[AW:1]];
                        if (we) begin
                            mem[adr[AW:1]] <= dat_w;
                        end
                    end else begin
                        busy      <= 1'b1;
                        wait_left <= delay - 1;
                    end
                end else if (wait_left == 0) begin
                    busy  <= 1'b0;
                    ack_q <= 1'b1;
                    dat_q <= mem[adr[AW:1]];
                    if (we) begin
                        mem[adr[AW:1]] <= dat_w;
                    end
                end else begin
                    wait_left <= wait_left - 1;
                end
            end
        end
    end

    // responses reach the DUT shortly after the edge
    assign #2 ack   = ack_q;
    assign #2 dat_r = dat_q;

endmodule : wb_memory_model

`default_nettype wire

// ==== tb/tb_cpu.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_cpu;

    import lc3b_types::*;

    localparam lc3b_word START_PC = 16'h0000;

    logic     clk;
    logic     rst_n;
    logic     imem_cyc;
    logic     imem_stb;
    lc3b_word imem_adr;
    lc3b_word imem_dat_r;
    logic     imem_ack;
    logic     dmem_cyc;
    logic     dmem_stb;
    logic     dmem_we;
    lc3b_word dmem_adr;
    lc3b_word dmem_dat_w;
    lc3b_word dmem_dat_r;
    logic     dmem_ack;
    logic     debug_reg_load;
    lc3b_reg  debug_reg_dest;
    lc3b_word debug_reg_data;

    // program at 0x00 and data init at 0x40 in the trace, then writes at 0x80 and stores at 0xe0
    lc3b_word trace [256];
    int       errors;
    int       tests;
    int       passed;
    int       failed;
    int       wr_idx;
    int       wr_total;
    int       st_idx;
    int       st_total;
    int       group_errors;
    int       store_errors;
    int       start_errors;
    int       extra_writes;
    int       cycles;

    cpu #(
        .RESET_PC(START_PC)
    ) cpu_inst (
        .clk,
        .rst_n,
        .imem_cyc,
        .imem_stb,
        .imem_adr,
        .imem_dat_r,
        .imem_ack,
        .dmem_cyc,
        .dmem_stb,
        .dmem_we,
        .dmem_adr,
        .dmem_dat_w,
        .dmem_dat_r,
        .dmem_ack,
        .debug_reg_load,
        .debug_reg_dest,
        .debug_reg_data
    );

    wb_memory_model imem_model (
        .clk, .rst_n, .cyc(imem_cyc), .stb(imem_stb), .we(1'b0), .adr(imem_adr),
        .dat_w(16'h0000), .dat_r(imem_dat_r), .ack(imem_ack)
    );

    wb_memory_model dmem_model (
        .clk, .rst_n, .cyc(dmem_cyc), .stb(dmem_stb), .we(dmem_we), .adr(dmem_adr),
        .dat_w(dmem_dat_w), .dat_r(dmem_dat_r), .ack(dmem_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic string group_name(int grp);
        case (grp)
            1: group_name = "alu results";
            2: group_name = "back-to-back dependence";
            3: group_name = "load store and load-use";
            4: group_name = "branches and counted loop";
            5: group_name = "unsupported opcodes";
            default: group_name = "unknown group";
        endcase
    endfunction

    task automatic report_test(string name, bit ok);
        tests++;
        if (ok) begin
            passed++;
            $display("test %s: passed", name);
        end else begin
            failed++;
            $display("test %s: failed", name);
        end
    endtask

    task automatic check_reg_write();
        int base;
        int grp;
        if (wr_idx >= wr_total) begin
            $display("unexpected register write r%0d = 0x%h after the expected sequence",
                     debug_reg_dest, debug_reg_data);
            errors++;
            extra_writes++;
        end else begin
            base = 129 + 3 * wr_idx;
            grp  = int'(trace[base]);
            if (debug_reg_dest !== trace[base + 1][2:0]) begin
                $display("mismatch debug_reg_dest: got 0x%h expected 0x%h at write %0d",
                         debug_reg_dest, trace[base + 1][2:0], wr_idx);
                errors++;
                group_errors++;
            end
            if (debug_reg_data !== trace[base + 2]) begin
                $display("mismatch debug_reg_data: got 0x%h expected 0x%h at write %0d",
                         debug_reg_data, trace[base + 2], wr_idx);
                errors++;
                group_errors++;
            end
            wr_idx++;
            // a group ends where the next record carries another group number
            if (wr_idx == wr_total || int'(trace[129 + 3 * wr_idx]) != grp) begin
                report_test(group_name(grp), group_errors == 0);
                group_errors = 0;
            end
        end
    endtask

    task automatic check_store();
        int base;
        if (st_idx >= st_total) begin
            $display("unexpected store of 0x%h to address 0x%h", dmem_dat_w, dmem_adr);
            errors++;
            store_errors++;
        end else begin
            base = 225 + 2 * st_idx;
            if (dmem_adr !== trace[base]) begin
                $display("mismatch dmem_adr: got 0x%h expected 0x%h at store %0d",
                         dmem_adr, trace[base], st_idx);
                errors++;
                store_errors++;
            end
            if (dmem_dat_w !== trace[base + 1]) begin
                $display("mismatch dmem_dat_w: got 0x%h expected 0x%h at store %0d",
                         dmem_dat_w, trace[base + 1], st_idx);
                errors++;
                store_errors++;
            end
            st_idx++;
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (debug_reg_load) begin
                check_reg_write();
            end
            if (dmem_cyc && dmem_stb && dmem_we && dmem_ack) begin
                check_store();
            end
        end
    end

    initial begin
        rst_n        = 1'b0;
        errors       = 0;
        tests        = 0;
        passed       = 0;
        failed       = 0;
        wr_idx       = 0;
        st_idx       = 0;
        group_errors = 0;
        store_errors = 0;
        start_errors = 0;
        extra_writes = 0;
        void'($urandom(76));

        for (int i = 0; i < 256; i++) begin
            trace[i] = 16'h0000;
        end
        $readmemh("tb/cpu_trace.txt", trace);

        for (int i = 0; i < 256; i++) begin
            // unsupported words that vary with the address fill the rest of imem
            imem_model.mem[i] = (i < 64) ? trace[i] : {8'hE0, 8'(i)};
            dmem_model.mem[i] = {8'(i), ~8'(i)};
        end
        for (int k = 0; k < int'(trace[64]); k++) begin
            dmem_model.mem[trace[65 + 2 * k][7:0]] = trace[66 + 2 * k];
        end
        wr_total = int'(trace[128]);
        st_total = int'(trace[224]);

        repeat (4) @(posedge clk);
        @(negedge clk);
        // both bus masters and the writeback port stay quiet in reset
        if ({imem_cyc, imem_stb, dmem_cyc, dmem_stb, dmem_we, debug_reg_load} !== 6'b0) begin
            $display("mismatch {imem_cyc,imem_stb,dmem_cyc,dmem_stb,dmem_we,debug_reg_load}: got 0x%h expected 0x00",
                     {imem_cyc, imem_stb, dmem_cyc, dmem_stb, dmem_we, debug_reg_load});
            errors++;
            start_errors++;
        end
        @(posedge clk);
        #2 rst_n = 1'b1;

        // first instruction request one cycle after reset
        @(posedge clk);
        @(negedge clk);
        if ({imem_cyc, imem_stb} !== 2'b11) begin
            $display("mismatch {imem_cyc,imem_stb}: got 0x%h expected 0x3",
                     {imem_cyc, imem_stb});
            errors++;
            start_errors++;
        end
        if (imem_adr !== START_PC) begin
            $display("mismatch imem_adr: got 0x%h expected 0x%h", imem_adr, START_PC);
            errors++;
            start_errors++;
        end
        report_test("reset and first fetch", start_errors == 0);

        cycles = 0;
        while (wr_idx < wr_total && cycles < 3000) begin
            @(posedge clk);
            cycles++;
        end
        if (wr_idx < wr_total) begin
            $display("timeout: only %0d of %0d register writes seen", wr_idx, wr_total);
            errors++;
            report_test("register write sequence", 1'b0);
        end

        // the program ends in a self loop and nothing more may retire
        cycles = 0;
        while (cycles < 40) begin
            @(posedge clk);
            cycles++;
        end
        if (st_idx != st_total) begin
            $display("only %0d of %0d stores seen", st_idx, st_total);
            errors++;
            store_errors++;
        end
        report_test("stores", store_errors == 0);
        report_test("no writes after program end", extra_writes == 0);

        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests, passed, failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : tb_cpu

`default_nettype wire

// ==== lc3b.f ====
verilog/lc3b_types.sv
verilog/pipeline_control.sv
verilog/fetch_unit.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/cpu.sv
tb/wb_memory_model.sv
tb/tb_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_cpu
FILELIST  ?= lc3b.f
SIM       ?= sim_$(TOP)
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(SIM)
	./obj_dir/$(SIM) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== tb/cpu_trace.txt ====
// program words from 0x00, data init at 0x40 as count then (word index, value)
// writes at 0x80 as count then (group, dest, value), stores at 0xe0 as count then (addr, data)
@00
5020 5260 1265 147D 1642 58C1 5AE6 9CFF 1F86
1021 1000 1000 903F
5260 1268 6441 1682 687E 5B03 7642 7840 6C42
0402 1022 0802 1021 1021 5FE0 1FE3 1B61 1FFF 03FD
E000 F025 4000 1261 0FFF
@40
0002 0002 8001 0005 1234
@80
001E
0001 0000 0000 0001 0001 0000 0001 0001 0005 0001 0002 0002 0001 0003 0007
0001 0004 0005 0001 0005 0006 0001 0006 FFF8 0001 0007 FFF0
0002 0000 0001 0002 0000 0002 0002 0000 0004 0002 0000 FFFB
0003 0001 0000 0003 0001 0008 0003 0002 1234 0003 0003 2468
0003 0004 8001 0003 0005 0000 0003 0006 2468
0004 0000 FFFD 0004 0007 0000 0004 0007 0003 0004 0005 0001 0004 0007 0002
0004 0005 0002 0004 0007 0001 0004 0005 0003 0004 0007 0000
0005 0001 0009
@E0
0002 000C 2468 0008 8001
